/* mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Word address width, one word per address
`define MEM_ADDR_W 12

// Word width of the 16-bit machine
`define MEM_DATA_W 16

// Store depth in words, equal to 2**MEM_ADDR_W
`define MEM_DEPTH 4096

// Osc cycles between two refresh requests
`define MEM_REF_INTERVAL 64

// Osc cycles a refresh keeps the store busy
`define MEM_REF_CYCLES 4

`endif

/* mem_pkg.sv */
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;  // Word address
  typedef logic [`MEM_DATA_W-1:0] mem_data_t;  // One data word

  // Requester side, held stable until rdy
  typedef struct packed {
    logic      valid;  // Request present
    logic      write;  // 1 = write, 0 = read
    logic      lock;   // Keep store for next bus cycle
    mem_addr_t addr;
    mem_data_t wdata;
  } mem_req_t;

  // Answer to one requester
  typedef struct packed {
    logic      rdy;    // Data-ready, one cycle
    mem_data_t rdata;  // Valid with rdy on reads
  } mem_rsp_t;

  // Current user of the store
  typedef enum logic [1:0] {
    own_none = 2'd0,  // Idle
    own_ref  = 2'd1,  // Refresh cycle
    own_cpu  = 2'd2,  // CPU port
    own_bus  = 2'd3   // System bus port
  } owner_e;

  // Arbiter to local bus control
  typedef struct packed {
    logic      start;  // One-cycle grant pulse
    owner_e    owner;
    logic      write;
    mem_addr_t addr;
    mem_data_t wdata;
  } mem_grant_t;

  // Local bus control to store
  typedef struct packed {
    logic      ras;    // Row strobe, gates the access
    logic      write;
    mem_addr_t addr;
    mem_data_t wdata;
  } dram_cmd_t;

endpackage

`default_nettype wire

/* refresh_timer.sv */
`default_nettype none

`include "mem_settings.svh"

module refresh_timer (
  input  logic osc,
  input  logic rst_n,
  input  logic ref_ack,  // Arbiter took the refresh
  output logic ref_req   // Pending refresh
);

  localparam int unsigned CNT_W = $clog2(`MEM_REF_INTERVAL);  // Holds interval - 1

  logic [CNT_W-1:0] cnt_q;  // Cycles left until next request

  // Counts down, then holds the request until acknowledged
  always_ff @(posedge osc) begin
    if (!rst_n) begin
      cnt_q   <= CNT_W'(`MEM_REF_INTERVAL - 1);
      ref_req <= 1'b0;
    end else if (ref_ack) begin
      cnt_q   <= CNT_W'(`MEM_REF_INTERVAL - 1);  // Restart interval
      ref_req <= 1'b0;
    end else if (cnt_q == '0) begin
      ref_req <= 1'b1;  // Stays high while store is busy
    end else begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
  input  logic                osc,
  input  logic                rst_n,
  input  mem_pkg::mem_req_t   cpu_req,
  input  mem_pkg::mem_req_t   bus_req,
  input  logic                ref_req,
  input  logic                done,     // End of access or refresh
  output logic                ref_ack,  // Pulse with a refresh grant
  output mem_pkg::mem_grant_t grant
);

  logic busy_q;  // Grant out, waiting for done
  logic lock_q;  // Bus holds the store
  logic avail;   // May grant this cycle
  logic pick_ref;
  logic pick_cpu;
  logic pick_bus;
  logic grant_go;

  logic               start_q;
  mem_pkg::owner_e    owner_q;
  logic               write_q;
  mem_pkg::mem_addr_t addr_q;
  mem_pkg::mem_data_t wdata_q;

  mem_pkg::owner_e   sel_owner;
  mem_pkg::mem_req_t sel_req;

  assign avail = !busy_q || done;  // Back to back on the done cycle

  // Refresh, then CPU, then bus; a held lock lets only the bus in
  always_comb begin
    pick_ref = 1'b0;
    pick_cpu = 1'b0;
    pick_bus = 1'b0;
    if (lock_q) begin
      pick_bus = bus_req.valid;
    end else if (ref_req) begin
      pick_ref = 1'b1;
    end else if (cpu_req.valid) begin
      pick_cpu = 1'b1;
    end else begin
      pick_bus = bus_req.valid;
    end
  end

  assign grant_go = avail && (pick_ref || pick_cpu || pick_bus);

  always_comb begin
    sel_owner = mem_pkg::own_none;
    sel_req   = '0;  // Refresh carries no payload
    if (pick_cpu) begin
      sel_owner = mem_pkg::own_cpu;
      sel_req   = cpu_req;
    end else if (pick_bus) begin
      sel_owner = mem_pkg::own_bus;
      sel_req   = bus_req;
    end else if (pick_ref) begin
      sel_owner = mem_pkg::own_ref;
    end
  end

  always_ff @(posedge osc) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      lock_q  <= 1'b0;
      start_q <= 1'b0;
      owner_q <= mem_pkg::own_none;
      ref_ack <= 1'b0;
    end else begin
      start_q <= grant_go;               // One-cycle start
      ref_ack <= grant_go && pick_ref;   // Timer clears its request
      if (grant_go) begin
        busy_q  <= 1'b1;
        owner_q <= sel_owner;
        if (pick_bus) begin
          lock_q <= bus_req.lock;        // Unlocked bus cycle releases
        end
      end else if (done) begin
        busy_q  <= 1'b0;
        owner_q <= mem_pkg::own_none;
      end
    end
  end

  // Request copy for the timing stage
  always_ff @(posedge osc) begin
    if (grant_go) begin
      write_q <= sel_req.write;
      addr_q  <= sel_req.addr;
      wdata_q <= sel_req.wdata;
    end
  end

  assign grant.start = start_q;
  assign grant.owner = owner_q;
  assign grant.write = write_q;
  assign grant.addr  = addr_q;
  assign grant.wdata = wdata_q;

endmodule

`default_nettype wire

/* lbd_timing.sv */
`default_nettype none

`include "mem_settings.svh"

module lbd_timing (
  input  logic                osc,
  input  logic                rst_n,
  input  mem_pkg::mem_grant_t grant,
  input  mem_pkg::mem_data_t  rd_word,  // Store output, valid after ras
  output mem_pkg::dram_cmd_t  cmd,
  output mem_pkg::mem_rsp_t   cpu_rsp,
  output mem_pkg::mem_rsp_t   bus_rsp,
  output logic                done      // Store free again
);

  localparam int unsigned REF_W = $clog2(`MEM_REF_CYCLES + 1);

  logic acc_start;  // Grant for a port access
  logic ref_start;  // Grant for a refresh

  // Grant delayed through the 25/50/75 taps, one osc each
  logic tap25_q;
  logic tap50_q;
  logic tap75_q;

  mem_pkg::owner_e    own_q;  // Owner latched at grant
  logic               write_q;
  mem_pkg::mem_addr_t addr_q;
  mem_pkg::mem_data_t wdata_q;

  logic [REF_W-1:0]   ref_cnt_q;  // Refresh cycles left
  logic               cpu_rdy_q;
  logic               bus_rdy_q;
  logic               done_q;
  mem_pkg::mem_data_t rdata_q;    // Read data at last tap

  assign acc_start = grant.start &&
                     (grant.owner == mem_pkg::own_cpu || grant.owner == mem_pkg::own_bus);
  assign ref_start = grant.start && (grant.owner == mem_pkg::own_ref);

  always_ff @(posedge osc) begin
    if (!rst_n) begin
      tap25_q   <= 1'b0;
      tap50_q   <= 1'b0;
      tap75_q   <= 1'b0;
      own_q     <= mem_pkg::own_none;
      ref_cnt_q <= '0;
      cpu_rdy_q <= 1'b0;
      bus_rdy_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      tap25_q <= acc_start;  // Only accesses walk the taps
      tap50_q <= tap25_q;
      tap75_q <= tap50_q;
      if (grant.start) begin
        own_q <= grant.owner;
      end
      if (ref_start) begin
        ref_cnt_q <= REF_W'(`MEM_REF_CYCLES);  // Hold store, no port strobe
      end else if (ref_cnt_q != '0) begin
        ref_cnt_q <= ref_cnt_q - REF_W'(1);
      end
      // Data-ready only on the port that owns the cycle
      cpu_rdy_q <= tap75_q && (own_q == mem_pkg::own_cpu);
      bus_rdy_q <= tap75_q && (own_q == mem_pkg::own_bus);
      done_q    <= tap75_q || (ref_cnt_q == REF_W'(1));
    end
  end

  // Access payload, taken with the grant
  always_ff @(posedge osc) begin
    if (acc_start) begin
      write_q <= grant.write;
      addr_q  <= grant.addr;
      wdata_q <= grant.wdata;
    end
  end

  // Read word captured at tap 75, writes keep the last value
  always_ff @(posedge osc) begin
    if (tap75_q && !write_q) begin
      rdata_q <= rd_word;
    end
  end

  assign cmd.ras   = tap50_q;  // Row strobe for one cycle at tap 50
  assign cmd.write = write_q;
  assign cmd.addr  = addr_q;
  assign cmd.wdata = wdata_q;

  assign cpu_rsp.rdy   = cpu_rdy_q;
  assign cpu_rsp.rdata = rdata_q;
  assign bus_rsp.rdy   = bus_rdy_q;
  assign bus_rsp.rdata = rdata_q;

  assign done = done_q;

endmodule

`default_nettype wire

/* dram_array.sv */
`default_nettype none

`include "mem_settings.svh"

module dram_array (
  input  logic               osc,
  input  mem_pkg::dram_cmd_t cmd,
  output mem_pkg::mem_data_t rd_word  // Registered read word
);

  mem_pkg::mem_data_t mem_q [`MEM_DEPTH];  // Word store

  // One word per row strobe, write or read
  always_ff @(posedge osc) begin
    if (cmd.ras) begin
      if (cmd.write) begin
        mem_q[cmd.addr] <= cmd.wdata;
      end else begin
        rd_word <= mem_q[cmd.addr];  // Ready the cycle after ras
      end
    end
  end

endmodule

`default_nettype wire

/* mem_board.sv */
`default_nettype none

module mem_board (
  input  logic              osc,
  input  logic              rst_n,
  input  mem_pkg::mem_req_t cpu_req,
  output mem_pkg::mem_rsp_t cpu_rsp,
  input  mem_pkg::mem_req_t bus_req,
  output mem_pkg::mem_rsp_t bus_rsp
);

  logic                ref_req;  // Timer to arbiter
  logic                ref_ack;  // Arbiter to timer
  logic                done;     // Timing stage to arbiter
  mem_pkg::mem_grant_t grant;
  mem_pkg::dram_cmd_t  cmd;
  mem_pkg::mem_data_t  rd_word;

  refresh_timer u_refresh_timer (
    .osc     (osc),
    .rst_n   (rst_n),
    .ref_ack (ref_ack),
    .ref_req (ref_req)
  );

  mem_arbiter u_mem_arbiter (
    .osc     (osc),
    .rst_n   (rst_n),
    .cpu_req (cpu_req),
    .bus_req (bus_req),
    .ref_req (ref_req),
    .done    (done),
    .ref_ack (ref_ack),
    .grant   (grant)
  );

  // Local bus control, grant to strobes and data-ready
  lbd_timing u_lbd_timing (
    .osc     (osc),
    .rst_n   (rst_n),
    .grant   (grant),
    .rd_word (rd_word),
    .cmd     (cmd),
    .cpu_rsp (cpu_rsp),
    .bus_rsp (bus_rsp),
    .done    (done)
  );

  dram_array u_dram_array (
    .osc     (osc),
    .cmd     (cmd),
    .rd_word (rd_word)
  );

endmodule

`default_nettype wire

/* tb_mem_board.sv */
`default_nettype none

`include "mem_settings.svh"

module tb_mem_board;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD    = 100;             // osc period in ns
  localparam int RESET_CYC = 4;
  localparam int IDLE_CYC  = 8;               // Quiet window after reset
  localparam int N_FIXED   = 16;              // Directed entries
  localparam int N_RANDOM  = 48;              // Back-to-back run across refreshes
  localparam int N_ENTRIES = N_FIXED + N_RANDOM;
  localparam int WD_CYC    = N_ENTRIES * (4 + `MEM_REF_CYCLES + 2) * 2 + RESET_CYC + IDLE_CYC;

  // One row of stimulus with its expected results
  typedef struct packed {
    logic [2:0]         group;      // Behavior under test
    mem_pkg::mem_req_t  cpu;        // valid marks an active port
    mem_pkg::mem_req_t  bus;
    logic               bus_first;  // Expected completion order
    mem_pkg::mem_data_t cpu_exp;
    mem_pkg::mem_data_t bus_exp;
  } entry_t;

  logic              osc;
  logic              rst_n;
  mem_pkg::mem_req_t cpu_req;
  mem_pkg::mem_rsp_t cpu_rsp;
  mem_pkg::mem_req_t bus_req;
  mem_pkg::mem_rsp_t bus_rsp;

  entry_t             table_q [N_ENTRIES];
  mem_pkg::mem_data_t model_mem [`MEM_DEPTH];  // Reference copy of the store
  mem_pkg::mem_addr_t written_q [$];           // Addresses safe to read back

  int seed      = 84;
  int cycle     = 0;  // Rising edges since start
  int ref_count = 0;  // Refresh grants seen
  int errors;
  int n_pass;
  int n_fail;

  mem_board u_mem_board (
    .osc     (osc),
    .rst_n   (rst_n),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

  initial begin
    osc = 1'b0;
    forever #(PERIOD / 2) osc = ~osc;
  end

  always @(posedge osc) begin
    cycle++;
    if (rst_n && u_mem_board.ref_ack) begin
      ref_count++;  // Arbiter took a refresh
    end
  end

  function automatic mem_pkg::mem_req_t make_req(input logic active, input logic write,
                                                  input logic lock, input int unsigned addr,
                                                  input int unsigned data);
    mem_pkg::mem_req_t req;
    req.valid = active;
    req.write = write;
    req.lock  = lock;
    req.addr  = mem_pkg::mem_addr_t'(addr);
    req.wdata = mem_pkg::mem_data_t'(data);
    return req;
  endfunction

  // Plays one request on the model, returns what a read would see
  function automatic mem_pkg::mem_data_t model_access(input mem_pkg::mem_req_t req);
    if (req.valid && req.write) begin
      model_mem[req.addr] = req.wdata;
      written_q.push_back(req.addr);
    end
    return model_mem[req.addr];
  endfunction

  // Random write, or read of a word already written
  function automatic mem_pkg::mem_req_t random_req();
    int unsigned pick;
    int unsigned addr;
    int unsigned data;
    pick = $unsigned($random(seed));
    data = $unsigned($random(seed));
    if (pick[0]) begin
      addr = $unsigned($random(seed));
      return make_req(1'b1, 1'b1, 1'b0, addr, data);
    end
    addr = 32'(written_q[(pick >> 1) % written_q.size()]);
    return make_req(1'b1, 1'b0, 1'b0, addr, data);
  endfunction

  task automatic add_entry(input int idx, input logic [2:0] group,
                           input mem_pkg::mem_req_t cpu, input mem_pkg::mem_req_t bus,
                           input logic bus_first);
    entry_t e;
    e           = '0;
    e.group     = group;
    e.cpu       = cpu;
    e.bus       = bus;
    e.bus_first = bus_first;
    if (bus_first) begin  // Model follows grant order
      e.bus_exp = model_access(bus);
      e.cpu_exp = model_access(cpu);
    end else begin
      e.cpu_exp = model_access(cpu);
      e.bus_exp = model_access(bus);
    end
    table_q[idx] = e;
  endtask

  task automatic build_table();
    mem_pkg::mem_req_t idle_req;
    idle_req = '0;
    add_entry(0, 3'd2, make_req(1'b1, 1'b1, 1'b0, 'h010, 'h1234), idle_req, 1'b0);
    add_entry(1, 3'd2, make_req(1'b1, 1'b0, 1'b0, 'h010, 'h0), idle_req, 1'b0);
    add_entry(2, 3'd2, make_req(1'b1, 1'b1, 1'b0, 'habc, 'hbeef), idle_req, 1'b0);
    add_entry(3, 3'd2, make_req(1'b1, 1'b0, 1'b0, 'habc, 'h0), idle_req, 1'b0);
    add_entry(4, 3'd2, make_req(1'b1, 1'b1, 1'b0, 'hfff, 'h5a5a), idle_req, 1'b0);
    add_entry(5, 3'd2, make_req(1'b1, 1'b0, 1'b0, 'hfff, 'h0), idle_req, 1'b0);
    // Shared store, bus to CPU and back
    add_entry(6, 3'd3, idle_req, make_req(1'b1, 1'b1, 1'b0, 'h123, 'hc0de), 1'b0);
    add_entry(7, 3'd3, make_req(1'b1, 1'b0, 1'b0, 'h123, 'h0), idle_req, 1'b0);
    add_entry(8, 3'd3, make_req(1'b1, 1'b1, 1'b0, 'h456, 'h7e57), idle_req, 1'b0);
    add_entry(9, 3'd3, idle_req, make_req(1'b1, 1'b0, 1'b0, 'h456, 'h0), 1'b0);
    // Same-cycle requests, CPU wins
    add_entry(10, 3'd4, make_req(1'b1, 1'b1, 1'b0, 'h200, 'h1111),
              make_req(1'b1, 1'b1, 1'b0, 'h201, 'h2222), 1'b0);
    add_entry(11, 3'd4, make_req(1'b1, 1'b0, 1'b0, 'h201, 'h0),
              make_req(1'b1, 1'b1, 1'b0, 'h201, 'h3333), 1'b0);
    add_entry(12, 3'd4, make_req(1'b1, 1'b1, 1'b0, 'h200, 'h4444),
              make_req(1'b1, 1'b0, 1'b0, 'h200, 'h0), 1'b0);
    // Locked read-modify-write on the bus
    add_entry(13, 3'd5, make_req(1'b1, 1'b1, 1'b0, 'h300, 'h0bad), idle_req, 1'b0);
    add_entry(14, 3'd5, idle_req, make_req(1'b1, 1'b0, 1'b1, 'h300, 'h0), 1'b0);
    add_entry(15, 3'd5, make_req(1'b1, 1'b0, 1'b0, 'h300, 'h0),
              make_req(1'b1, 1'b1, 1'b0, 'h300, 'hf00d), 1'b1);  // Lock beats CPU
    for (int i = N_FIXED; i < N_ENTRIES; i++) begin
      add_entry(i, 3'd6, random_req(), random_req(), 1'b0);
    end
  endtask

  task automatic record_result(input string label, input int err_before);
    if (errors == err_before) begin
      n_pass++;
      $display("%s passed at cycle %0d", label, cycle);
    end else begin
      n_fail++;
      $display("%s failed at cycle %0d", label, cycle);
    end
  endtask

  // Drives one entry from the current falling edge until every active port is done
  task automatic run_entry(input int idx);
    entry_t e;
    logic   cpu_wait;
    logic   bus_wait;
    int     cpu_at;
    int     bus_at;
    e        = table_q[idx];
    cpu_wait = e.cpu.valid;
    bus_wait = e.bus.valid;
    cpu_at   = 0;
    bus_at   = 0;
    cpu_req  = e.cpu;
    bus_req  = e.bus;
    while (cpu_wait || bus_wait) begin
      @(negedge osc);
      if (cpu_rsp.rdy) begin
        assert (cpu_wait) else begin
          $display("Entry %0d: data-ready on the CPU port with nothing pending", idx);
          errors++;
        end
        if (cpu_wait && !e.cpu.write) begin
          assert (cpu_rsp.rdata == e.cpu_exp) else begin
            $display("[FAIL] entry %0d cpu_rsp.rdata got %h expected %h",
                     idx, cpu_rsp.rdata, e.cpu_exp);
            errors++;
          end
        end
        cpu_wait = 1'b0;
        cpu_at   = cycle;
        cpu_req  = '0;  // Drop valid in the rdy cycle
      end
      if (bus_rsp.rdy) begin
        assert (bus_wait) else begin
          $display("Entry %0d: data-ready on the bus port with nothing pending", idx);
          errors++;
        end
        if (bus_wait && !e.bus.write) begin
          assert (bus_rsp.rdata == e.bus_exp) else begin
            $display("[FAIL] entry %0d bus_rsp.rdata got %h expected %h",
                     idx, bus_rsp.rdata, e.bus_exp);
            errors++;
          end
        end
        bus_wait = 1'b0;
        bus_at   = cycle;
        bus_req  = '0;
      end
    end
    if (e.cpu.valid && e.bus.valid) begin
      assert (cpu_at != bus_at) else begin
        $display("Entry %0d: both ports signalled data-ready in the same cycle", idx);
        errors++;
      end
      assert ((bus_at < cpu_at) == e.bus_first) else begin
        $display("[FAIL] entry %0d bus_first got %h expected %h",
                 idx, bus_at < cpu_at, e.bus_first);
        errors++;
      end
    end
  endtask

  initial begin : main_seq
    int err_before;
    rst_n   = 1'b0;
    cpu_req = '0;
    bus_req = '0;
    errors  = 0;
    n_pass  = 0;
    n_fail  = 0;
    build_table();
    repeat (RESET_CYC) @(posedge osc);
    @(negedge osc);
    rst_n = 1'b1;
    err_before = errors;
    repeat (IDLE_CYC) begin  // No request, so no data-ready
      @(negedge osc);
      assert (!cpu_rsp.rdy && !bus_rsp.rdy) else begin
        $display("[FAIL] idle cpu_rsp.rdy %h bus_rsp.rdy %h expected 0",
                 cpu_rsp.rdy, bus_rsp.rdy);
        errors++;
      end
    end
    record_result("idle after reset, behavior 1", err_before);
    for (int i = 0; i < N_ENTRIES; i++) begin
      err_before = errors;
      run_entry(i);
      record_result($sformatf("entry %0d, behavior %0d", i, table_q[i].group), err_before);
    end
    err_before = errors;
    assert (ref_count >= cycle / (2 * `MEM_REF_INTERVAL)) else begin
      $display("Only %0d refresh cycles ran in %0d cycles", ref_count, cycle);
      errors++;
    end
    record_result("refresh during the back-to-back run", err_before);
    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WD_CYC * PERIOD);
    $display("Timeout after %0d cycles, a request never completed", WD_CYC);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
mem_pkg.sv
refresh_timer.sv
mem_arbiter.sv
lbd_timing.sv
dram_array.sv
mem_board.sv
tb_mem_board.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the memory board testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_board -f verilog.f -o sim_mem_board
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mem_board > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

exit 0
